/* hw/nn_fixed_pkg.sv */
package nn_fixed_pkg;

    localparam int FRAC_BITS = 8; // Q8.8 for every value in the datapath

    typedef logic signed [15:0] act_t; // activations, deltas and targets
    typedef logic signed [15:0] wt_t;
    typedef logic signed [31:0] acc_t; // products and their sums

    localparam act_t ACT_MAX = act_t'(16'h7fff);
    localparam act_t ACT_MIN = act_t'(16'h8000);

    // a sum of Q8.8 x Q8.8 products carries 16 fraction bits
    // bring it back to Q8.8 and clamp instead of wrapping
    function automatic act_t sat_act(input acc_t acc);
        acc_t scaled;
        scaled = acc >>> FRAC_BITS;
        if (scaled > acc_t'(ACT_MAX)) begin
            return ACT_MAX;
        end else if (scaled < acc_t'(ACT_MIN)) begin
            return ACT_MIN;
        end
        return act_t'(scaled);
    endfunction

endpackage

/* hw/nn_ctrl_pkg.sv */
package nn_ctrl_pkg;

    // epoch sequencing states
    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        FP,
        BP
    } ctrl_state_t;

    typedef logic cfg_addr_t;

    localparam cfg_addr_t CFG_NUM_SAMPLES = 1'b0;
    localparam cfg_addr_t CFG_LR_SHIFT    = 1'b1;

    localparam int CFG_DATA_W = 16; // register data width
    localparam int LR_SHIFT_W = 4;

endpackage

/* hw/sample_mem.sv */
`timescale 1ns/1ps

module sample_mem #(
    parameter type T       = logic,
    parameter int  DEPTH_W = 4
) (
    input  logic               clk,
    input  logic               wr,
    input  logic [DEPTH_W-1:0] wr_addr,
    input  logic [DEPTH_W-1:0] rd_addr,
    input  T                   wr_data,
    output T                   rd_data
);

    T mem [2**DEPTH_W];

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr]; // data shows up one cycle after the address
    end

endmodule

/* hw/train_config.sv */
`timescale 1ns/1ps

module train_config #(
    parameter int SAMPLE_ADDR_W = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cfg_wr,
    input  nn_ctrl_pkg::cfg_addr_t              cfg_addr,
    input  logic [nn_ctrl_pkg::CFG_DATA_W-1:0]  cfg_wdata,
    output logic [nn_ctrl_pkg::CFG_DATA_W-1:0]  cfg_rdata,
    output logic [SAMPLE_ADDR_W:0]              num_samples,
    output logic [nn_ctrl_pkg::LR_SHIFT_W-1:0]  lr_shift
);

    import nn_ctrl_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            num_samples <= '0;
            lr_shift    <= '0;
        end else if (cfg_wr) begin
            case (cfg_addr)
                CFG_NUM_SAMPLES: num_samples <= cfg_wdata[SAMPLE_ADDR_W:0];
                CFG_LR_SHIFT:    lr_shift    <= cfg_wdata[LR_SHIFT_W-1:0]; // upper bits dropped
                default:         ;
            endcase
        end
    end

    // readback, unused upper bits read as zero
    always_comb begin
        cfg_rdata = '0;
        case (cfg_addr)
            CFG_NUM_SAMPLES: cfg_rdata[SAMPLE_ADDR_W:0] = num_samples;
            CFG_LR_SHIFT:    cfg_rdata[LR_SHIFT_W-1:0]  = lr_shift;
            default:         cfg_rdata = '0;
        endcase
    end

endmodule

/* hw/activation_stack.sv */
`timescale 1ns/1ps

module activation_stack #(
    parameter int NEURON_NUM   = 2,
    parameter int LAYER_MAX    = 3,
    parameter int LAYER_ADDR_W = 2
) (
    input  logic                                    clk,
    input  logic                                    wr_en,
    input  logic [LAYER_ADDR_W-1:0]                 wr_addr,
    input  nn_fixed_pkg::act_t [NEURON_NUM-1:0]     wr_data,
    input  logic [LAYER_ADDR_W-1:0]                 rd_addr,
    output nn_fixed_pkg::act_t [NEURON_NUM-1:0]     rd_data,
    output nn_fixed_pkg::act_t [NEURON_NUM-1:0]     rd_data_prev
);

    import nn_fixed_pkg::*;

    act_t [NEURON_NUM-1:0] stack [LAYER_MAX]; // one activation vector per layer

    always_ff @(posedge clk) begin
        if (wr_en) begin
            stack[wr_addr] <= wr_data;
        end
    end

    // layer l and the layer feeding it
    assign rd_data      = stack[rd_addr];
    assign rd_data_prev = stack[rd_addr - 1'b1];

endmodule

/* hw/forward_layer.sv */
`timescale 1ns/1ps

module forward_layer #(
    parameter int NEURON_NUM   = 2,
    parameter int LAYER_ADDR_W = 2
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            start,
    input  logic [LAYER_ADDR_W-1:0]                         layer,
    input  nn_fixed_pkg::act_t [NEURON_NUM-1:0]             a_in,
    input  nn_fixed_pkg::wt_t  [NEURON_NUM*NEURON_NUM-1:0]  weights,
    output logic                                            done,
    output nn_fixed_pkg::act_t [NEURON_NUM-1:0]             z_out
);

    import nn_fixed_pkg::*;

    localparam int IDX_W = $clog2(NEURON_NUM);

    logic             running;
    logic [IDX_W-1:0] cnt;   // input column being summed
    logic             last;
    wt_t              w_eff [NEURON_NUM];
    acc_t             prod  [NEURON_NUM];
    acc_t             acc   [NEURON_NUM];

    assign last = running && (cnt == IDX_W'(NEURON_NUM - 1));

    always_comb begin
        for (int i = 0; i < NEURON_NUM; i++) begin
            w_eff[i] = weights[i*NEURON_NUM + cnt];
            prod[i] = acc_t'(w_eff[i]) * acc_t'(a_in[cnt]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            cnt     <= '0;
            done    <= 1'b0;
        end else begin
            done <= last; // NEURON_NUM+1 cycles after start
            if (start) begin
                running <= 1'b1;
                cnt     <= '0;
            end else if (running) begin
                cnt <= cnt + 1'b1;
                if (last) begin
                    running <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NEURON_NUM; i++) begin
            if (start) begin
                acc[i] <= '0;
            end else if (running) begin
                acc[i] <= acc[i] + prod[i];
            end
            if (last) begin
                z_out[i] <= sat_act(acc[i] + prod[i]); // linear activation, saturated
            end
        end
    end

endmodule

/* hw/backpropagator.sv */
`timescale 1ns/1ps

module backpropagator #(
    parameter int NEURON_NUM   = 2,
    parameter int LAYER_MAX    = 3,
    parameter int LAYER_ADDR_W = 2
) (
    input  logic                                                clk,
    input  logic                                                rst,
    input  logic                                                start,
    input  logic [LAYER_ADDR_W-1:0]                             layer,
    input  nn_fixed_pkg::act_t [NEURON_NUM-1:0]                 z,
    input  nn_fixed_pkg::act_t [NEURON_NUM-1:0]                 a_prev,
    input  nn_fixed_pkg::act_t [NEURON_NUM-1:0]                 target,
    input  logic [nn_ctrl_pkg::LR_SHIFT_W-1:0]                  lr_shift,
    input  logic                                                wt_wr,
    input  logic [LAYER_ADDR_W+2*$clog2(NEURON_NUM)-1:0]        wt_addr,
    input  nn_fixed_pkg::wt_t                                   wt_wdata,
    output nn_fixed_pkg::wt_t                                   wt_rdata,
    output nn_fixed_pkg::wt_t  [NEURON_NUM*NEURON_NUM-1:0]      layer_weights,
    output logic                                                done
);

    import nn_fixed_pkg::*;

    localparam int IDX_W = $clog2(NEURON_NUM);

    typedef enum logic [1:0] {
        BP_IDLE,
        BP_PROP,
        BP_UPD
    } bp_state_t;

    bp_state_t               state;
    logic [IDX_W-1:0]        row;
    logic [IDX_W-1:0]        col;
    logic                    row_last;
    logic                    col_last;
    logic                    top_layer;
    logic [LAYER_ADDR_W-1:0] ext_l;
    logic [IDX_W-1:0]        ext_r;
    logic [IDX_W-1:0]        ext_c;
    wt_t                     w        [LAYER_MAX][NEURON_NUM][NEURON_NUM];
    act_t                    delta    [NEURON_NUM];
    acc_t                    prop_acc [NEURON_NUM]; // error sent down to layer-1
    acc_t                    upd_prod;
    wt_t                     upd_step;

    assign {ext_l, ext_r, ext_c} = wt_addr;
    assign wt_rdata  = w[ext_l][ext_r][ext_c];
    assign top_layer = (layer == LAYER_ADDR_W'(LAYER_MAX - 1));
    assign row_last  = (row == IDX_W'(NEURON_NUM - 1));
    assign col_last  = (col == IDX_W'(NEURON_NUM - 1));

    always_comb begin
        for (int i = 0; i < NEURON_NUM; i++) begin
            for (int j = 0; j < NEURON_NUM; j++) begin
                layer_weights[i*NEURON_NUM + j] = w[layer][i][j];
            end
        end
    end

    // gradient step for w[layer][row][col]
    assign upd_prod = acc_t'(delta[row]) * acc_t'(a_prev[col]);
    assign upd_step = wt_t'(upd_prod >>> (FRAC_BITS + lr_shift));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= BP_IDLE;
            row   <= '0;
            col   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                BP_IDLE: if (start) begin
                    state <= BP_PROP;
                    row   <= '0;
                end
                BP_PROP: begin // one row of old weights per cycle
                    row <= row + 1'b1;
                    if (row_last) begin
                        state <= BP_UPD;
                        row   <= '0;
                        col   <= '0;
                    end
                end
                BP_UPD: begin // one weight per cycle
                    col <= col + 1'b1;
                    if (col_last) begin
                        col <= '0;
                        row <= row + 1'b1;
                        if (row_last) begin
                            state <= BP_IDLE;
                            done  <= 1'b1;
                        end
                    end
                end
                default: state <= BP_IDLE;
            endcase
        end
    end

    // delta is taken in the start cycle, target is only valid then
    // below the top, it is what the layer above sent down before its own update
    always_ff @(posedge clk) begin
        for (int i = 0; i < NEURON_NUM; i++) begin
            if (state == BP_IDLE && start) begin
                delta[i]    <= top_layer ?
                               sat_act((acc_t'(z[i]) - acc_t'(target[i])) <<< FRAC_BITS) :
                               sat_act(prop_acc[i]);
                prop_acc[i] <= '0;
            end else if (state == BP_PROP) begin
                prop_acc[i] <= prop_acc[i] + acc_t'(w[layer][row][i]) * acc_t'(delta[row]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wt_wr) begin
            w[ext_l][ext_r][ext_c] <= wt_wdata;
        end else if (state == BP_UPD) begin
            w[layer][row][col] <= w[layer][row][col] - upd_step;
        end
    end

endmodule

/* hw/train_controller.sv */
`timescale 1ns/1ps

module train_controller #(
    parameter int LAYER_MAX     = 3,
    parameter int LAYER_ADDR_W  = 2,
    parameter int SAMPLE_ADDR_W = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic [SAMPLE_ADDR_W:0]  num_samples,
    input  logic                    fp_done,
    input  logic                    bp_done,
    output logic                    fp_start,
    output logic                    bp_start,
    output logic [LAYER_ADDR_W-1:0] layer,
    output logic [SAMPLE_ADDR_W:0]  sample_idx,
    output logic                    stack_wr_sel,
    output logic                    busy,
    output logic                    sample_done,
    output logic                    epoch_done
);

    import nn_ctrl_pkg::*;

    localparam logic [LAYER_ADDR_W-1:0] TOP = LAYER_ADDR_W'(LAYER_MAX - 1);
    localparam logic [LAYER_ADDR_W-1:0] L1  = LAYER_ADDR_W'(1);

    ctrl_state_t state;

    assign busy         = (state != IDLE);
    assign stack_wr_sel = (state == LOAD); // sample input goes into layer 0

    // the index moves on as layer 1 BP starts, so the registered sample
    // read already holds the next input when LOAD comes round
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            layer       <= '0;
            sample_idx  <= '0;
            fp_start    <= 1'b0;
            bp_start    <= 1'b0;
            sample_done <= 1'b0;
            epoch_done  <= 1'b0;
        end else begin
            fp_start    <= 1'b0;
            bp_start    <= 1'b0;
            sample_done <= 1'b0;
            epoch_done  <= 1'b0;
            case (state)
                IDLE: begin
                    if (start && num_samples == '0) begin
                        epoch_done <= 1'b1; // nothing to train on
                    end else if (start) begin
                        state <= LOAD;
                        layer <= '0;
                    end
                end
                LOAD: begin
                    state    <= FP;
                    layer    <= L1;
                    fp_start <= 1'b1;
                end
                FP: begin
                    if (fp_done && layer == TOP) begin
                        state       <= BP; // top layer stays selected
                        bp_start    <= 1'b1;
                        sample_done <= 1'b1;
                        if (TOP == L1) begin
                            sample_idx <= sample_idx + 1'b1;
                        end
                    end else if (fp_done) begin
                        layer    <= layer + 1'b1;
                        fp_start <= 1'b1;
                    end
                end
                BP: begin
                    if (bp_done && layer == L1) begin
                        if (sample_idx == num_samples) begin
                            state      <= IDLE;
                            epoch_done <= 1'b1;
                            sample_idx <= '0;
                        end else begin
                            state <= LOAD;
                            layer <= '0;
                        end
                    end else if (bp_done) begin
                        layer    <= layer - 1'b1;
                        bp_start <= 1'b1;
                        if (layer == L1 + 1'b1) begin
                            sample_idx <= sample_idx + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* hw/nn_trainer.sv */
`timescale 1ns/1ps

module nn_trainer #(
    parameter int NEURON_NUM    = 2,
    parameter int LAYER_MAX     = 3,
    parameter int LAYER_ADDR_W  = 2,
    parameter int SAMPLE_ADDR_W = 4
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            smp_wr,
    input  logic [SAMPLE_ADDR_W-1:0]                        smp_addr,
    input  nn_fixed_pkg::act_t [NEURON_NUM-1:0]             smp_input,
    input  nn_fixed_pkg::act_t [NEURON_NUM-1:0]             smp_target,
    input  logic                                            wt_wr,
    input  logic [LAYER_ADDR_W+2*$clog2(NEURON_NUM)-1:0]    wt_addr,
    input  nn_fixed_pkg::wt_t                               wt_wdata,
    output nn_fixed_pkg::wt_t                               wt_rdata,
    input  logic                                            cfg_wr,
    input  nn_ctrl_pkg::cfg_addr_t                          cfg_addr,
    input  logic [nn_ctrl_pkg::CFG_DATA_W-1:0]              cfg_wdata,
    output logic [nn_ctrl_pkg::CFG_DATA_W-1:0]              cfg_rdata,
    input  logic                                            start,
    output logic                                            busy,
    output logic                                            sample_done,
    output nn_fixed_pkg::act_t [NEURON_NUM-1:0]             out_vec,
    output logic                                            epoch_done
);

    import nn_fixed_pkg::*;

    typedef act_t [NEURON_NUM-1:0] vec_t;

    vec_t                                   smp_in_rd, smp_tgt_rd, fp_out;
    vec_t                                   stack_rd, stack_rd_prev, stack_wr_data;
    wt_t [NEURON_NUM*NEURON_NUM-1:0]        layer_weights;
    logic [SAMPLE_ADDR_W:0]                 num_samples, sample_idx;
    logic [nn_ctrl_pkg::LR_SHIFT_W-1:0]     lr_shift;
    logic [LAYER_ADDR_W-1:0]                layer;
    logic                                   fp_start, fp_done, bp_start, bp_done;
    logic                                   stack_wr_sel, stack_wr_en;

    assign stack_wr_en   = stack_wr_sel | fp_done;
    assign stack_wr_data = stack_wr_sel ? smp_in_rd : fp_out;
    assign out_vec       = fp_out; // holds the top layer result through BP

    sample_mem #(.T(vec_t), .DEPTH_W(SAMPLE_ADDR_W)) u_input_mem (
        .clk(clk), .wr(smp_wr), .wr_addr(smp_addr), .rd_addr(sample_idx[SAMPLE_ADDR_W-1:0]),
        .wr_data(smp_input), .rd_data(smp_in_rd));

    sample_mem #(.T(vec_t), .DEPTH_W(SAMPLE_ADDR_W)) u_target_mem (
        .clk(clk), .wr(smp_wr), .wr_addr(smp_addr), .rd_addr(sample_idx[SAMPLE_ADDR_W-1:0]),
        .wr_data(smp_target), .rd_data(smp_tgt_rd));

    train_config #(.SAMPLE_ADDR_W(SAMPLE_ADDR_W)) u_train_config (
        .clk(clk), .rst(rst), .cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .cfg_rdata(cfg_rdata), .num_samples(num_samples), .lr_shift(lr_shift));

    train_controller #(.LAYER_MAX(LAYER_MAX), .LAYER_ADDR_W(LAYER_ADDR_W),
                       .SAMPLE_ADDR_W(SAMPLE_ADDR_W)) u_train_controller (
        .clk(clk), .rst(rst), .start(start), .num_samples(num_samples),
        .fp_done(fp_done), .bp_done(bp_done), .fp_start(fp_start), .bp_start(bp_start),
        .layer(layer), .sample_idx(sample_idx), .stack_wr_sel(stack_wr_sel),
        .busy(busy), .sample_done(sample_done), .epoch_done(epoch_done));

    activation_stack #(.NEURON_NUM(NEURON_NUM), .LAYER_MAX(LAYER_MAX),
                       .LAYER_ADDR_W(LAYER_ADDR_W)) u_activation_stack (
        .clk(clk), .wr_en(stack_wr_en), .wr_addr(layer), .wr_data(stack_wr_data),
        .rd_addr(layer), .rd_data(stack_rd), .rd_data_prev(stack_rd_prev));

    forward_layer #(.NEURON_NUM(NEURON_NUM), .LAYER_ADDR_W(LAYER_ADDR_W)) u_forward_layer (
        .clk(clk), .rst(rst), .start(fp_start), .layer(layer), .a_in(stack_rd_prev),
        .weights(layer_weights), .done(fp_done), .z_out(fp_out));

    backpropagator #(.NEURON_NUM(NEURON_NUM), .LAYER_MAX(LAYER_MAX),
                     .LAYER_ADDR_W(LAYER_ADDR_W)) u_backpropagator (
        .clk(clk), .rst(rst), .start(bp_start), .layer(layer), .z(stack_rd),
        .a_prev(stack_rd_prev), .target(smp_tgt_rd), .lr_shift(lr_shift),
        .wt_wr(wt_wr), .wt_addr(wt_addr), .wt_wdata(wt_wdata), .wt_rdata(wt_rdata),
        .layer_weights(layer_weights), .done(bp_done));

endmodule

/* tests/nn_ref_model.svh */
wt_t  m_w     [LAYER_MAX][N][N]; // model copy of every weight
vec_t s_in    [SAMPLES];
vec_t s_tgt   [SAMPLES];
vec_t exp_out [64];              // expected out_vec, in sample_done order
int   exp_total = 0;

function automatic acc_t widen(input act_t v);
    return acc_t'(v); // sign extended
endfunction

// clamp into the signed 16-bit range
function automatic act_t clamp16(input acc_t v);
    if (v > acc_t'(32767)) begin
        return act_t'(16'h7fff);
    end
    if (v < acc_t'(-32768)) begin
        return act_t'(16'h8000);
    end
    return act_t'(v[15:0]);
endfunction

function automatic act_t clamp_q88(input acc_t sum);
    return clamp16(sum >>> FRAC_BITS); // sum of products has 16 fraction bits
endfunction

// forward pass, then backprop from the top layer down to layer 1
task automatic model_sample(input int k, input int lr, output vec_t top);
    vec_t a      [LAYER_MAX];
    act_t delta  [N];
    act_t d_down [N];
    acc_t sum;
    wt_t  step;
    a[0] = s_in[k];
    for (int l = 1; l < LAYER_MAX; l++) begin
        for (int i = 0; i < N; i++) begin
            sum = 0;
            for (int j = 0; j < N; j++) begin
                sum = sum + widen(m_w[l][i][j]) * widen(a[l-1][j]);
            end
            a[l][i] = clamp_q88(sum);
        end
    end
    top = a[LAYER_MAX-1];
    for (int i = 0; i < N; i++) begin
        delta[i] = clamp16(widen(top[i]) - widen(s_tgt[k][i])); // output error
    end
    for (int l = LAYER_MAX - 1; l >= 1; l--) begin
        // error sent down uses the weights before this layer's update
        for (int j = 0; j < N; j++) begin
            sum = 0;
            for (int i = 0; i < N; i++) begin
                sum = sum + widen(m_w[l][i][j]) * widen(delta[i]);
            end
            d_down[j] = clamp_q88(sum);
        end
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                step = wt_t'((widen(delta[i]) * widen(a[l-1][j])) >>> (FRAC_BITS + lr));
                m_w[l][i][j] = m_w[l][i][j] - step;
            end
        end
        delta = d_down;
    end
endtask

task automatic model_epoch(input int n, input int lr);
    vec_t top;
    for (int k = 0; k < n; k++) begin
        model_sample(k, lr, top);
        exp_out[exp_total] = top;
        exp_total++;
    end
endtask

/* tests/tb_nn_trainer.sv */
`timescale 1ns/1ps

module tb_nn_trainer;

    import nn_fixed_pkg::*;
    import nn_ctrl_pkg::*;

    localparam int N               = 2;
    localparam int LAYER_MAX       = 3;
    localparam int LAYER_ADDR_W    = 2;
    localparam int SAMPLE_ADDR_W   = 4;
    localparam int SAMPLES         = 2**SAMPLE_ADDR_W;
    localparam int IDX_W           = $clog2(N);
    localparam int WT_ADDR_W       = LAYER_ADDR_W + 2*IDX_W;
    localparam int RUN_SAMPLES     = 4;
    localparam int TOTAL_SAMPLES   = 3*RUN_SAMPLES; // three epochs that train
    localparam int WATCHDOG_CYCLES = 4*TOTAL_SAMPLES*LAYER_MAX*(N*N + 8) + 2000;
    localparam logic [31:0] SEED   = 32'hc829;

    typedef act_t [N-1:0] vec_t;

    logic                     clk;
    logic                     rst;
    logic                     smp_wr;
    logic [SAMPLE_ADDR_W-1:0] smp_addr;
    vec_t                     smp_input;
    vec_t                     smp_target;
    logic                     wt_wr;
    logic [WT_ADDR_W-1:0]     wt_addr;
    wt_t                      wt_wdata;
    wt_t                      wt_rdata;
    logic                     cfg_wr;
    cfg_addr_t                cfg_addr;
    logic [CFG_DATA_W-1:0]    cfg_wdata;
    logic [CFG_DATA_W-1:0]    cfg_rdata;
    logic                     start;
    logic                     busy;
    logic                     sample_done;
    vec_t                     out_vec;
    logic                     epoch_done;

    int   errors = 0;
    int   smp_seen;     // sample_done pulses over the whole run
    int   epoch_smp;    // sample_done pulses in the running epoch
    int   epoch_expect;
    vec_t exp_now;

    nn_trainer #(
        .NEURON_NUM(N), .LAYER_MAX(LAYER_MAX), .LAYER_ADDR_W(LAYER_ADDR_W),
        .SAMPLE_ADDR_W(SAMPLE_ADDR_W)
    ) u_nn_trainer (
        .clk(clk), .rst(rst), .smp_wr(smp_wr), .smp_addr(smp_addr), .smp_input(smp_input),
        .smp_target(smp_target), .wt_wr(wt_wr), .wt_addr(wt_addr), .wt_wdata(wt_wdata),
        .wt_rdata(wt_rdata), .cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .cfg_rdata(cfg_rdata), .start(start), .busy(busy), .sample_done(sample_done),
        .out_vec(out_vec), .epoch_done(epoch_done));

    `include "nn_ref_model.svh"

    always #20 clk = ~clk;

    assign exp_now = exp_out[smp_seen];

    always @(posedge clk) begin
        if (rst) begin
            smp_seen  <= 0;
            epoch_smp <= 0;
        end else begin
            if (sample_done) smp_seen <= smp_seen + 1;
            if (epoch_done) begin
                epoch_smp <= 0;
            end else if (sample_done) begin
                epoch_smp <= epoch_smp + 1;
            end
        end
    end

    a_out_vec: assert property (@(posedge clk) disable iff (rst)
        sample_done |-> out_vec == exp_now)
    else begin
        errors++;
        $display("ERROR out_vec sample %0d expected %h got %h",
                 $sampled(smp_seen), $sampled(exp_now), $sampled(out_vec));
    end

    a_count: assert property (@(posedge clk) disable iff (rst)
        epoch_done |-> epoch_smp == epoch_expect)
    else begin
        errors++;
        $display("ERROR sample_done count expected %h got %h",
                 $sampled(epoch_expect), $sampled(epoch_smp));
    end

    a_busy_end: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> epoch_done)
    else begin
        errors++;
        $display("busy went low without an epoch_done pulse");
    end

    a_idle_at_end: assert property (@(posedge clk) disable iff (rst)
        epoch_done |-> !busy)
    else begin
        errors++;
        $display("busy still high while epoch_done pulsed");
    end

    a_sample_busy: assert property (@(posedge clk) disable iff (rst)
        sample_done |-> busy)
    else begin
        errors++;
        $display("sample_done pulsed while busy was low");
    end

    a_busy_start: assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> $past(start))
    else begin
        errors++;
        $display("busy went high without a start pulse");
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    function automatic act_t rand_q88(input int mag);
        int r;
        r = int'($urandom % (2*mag)) - mag;
        return act_t'(r);
    endfunction

    function automatic logic [WT_ADDR_W-1:0] wt_index(input int l, input int i, input int j);
        return {LAYER_ADDR_W'(l), IDX_W'(i), IDX_W'(j)};
    endfunction

    task automatic write_cfg(input cfg_addr_t a, input logic [CFG_DATA_W-1:0] d);
        cfg_wr    = 1'b1;
        cfg_addr  = a;
        cfg_wdata = d;
        next_cycle();
        cfg_wr = 1'b0;
    endtask

    task automatic check_cfg(input cfg_addr_t a, input logic [CFG_DATA_W-1:0] e);
        cfg_addr = a;
        #1;
        assert (cfg_rdata == e) else begin
            errors++;
            $display("ERROR cfg_rdata at %0d expected %h got %h", a, e, cfg_rdata);
        end
    endtask

    // every entry gets data, so a wrong sample index shows up in out_vec
    task automatic load_samples();
        for (int s = 0; s < SAMPLES; s++) begin
            for (int i = 0; i < N; i++) begin
                s_in[s][i]  = rand_q88(256); // within +-1.0
                s_tgt[s][i] = rand_q88(256);
            end
            smp_wr     = 1'b1;
            smp_addr   = SAMPLE_ADDR_W'(s);
            smp_input  = s_in[s];
            smp_target = s_tgt[s];
            next_cycle();
        end
        smp_wr = 1'b0;
    endtask

    task automatic load_weights(input int mag);
        for (int l = 0; l < LAYER_MAX; l++) begin
            for (int i = 0; i < N; i++) begin
                for (int j = 0; j < N; j++) begin
                    m_w[l][i][j] = rand_q88(mag);
                    wt_wr        = 1'b1;
                    wt_addr      = wt_index(l, i, j);
                    wt_wdata     = m_w[l][i][j];
                    next_cycle();
                end
            end
        end
        wt_wr = 1'b0;
    endtask

    task automatic check_weights();
        for (int l = 1; l < LAYER_MAX; l++) begin
            for (int i = 0; i < N; i++) begin
                for (int j = 0; j < N; j++) begin
                    next_cycle();
                    wt_addr = wt_index(l, i, j);
                    #1;
                    assert (wt_rdata == m_w[l][i][j]) else begin
                        errors++;
                        $display("ERROR wt_rdata[%0d][%0d][%0d] expected %h got %h",
                                 l, i, j, m_w[l][i][j], wt_rdata);
                    end
                end
            end
        end
    endtask

    task automatic run_epoch(input int n, input int lr, input bit poke);
        write_cfg(CFG_NUM_SAMPLES, 16'(n));
        write_cfg(CFG_LR_SHIFT, 16'(lr));
        model_epoch(n, lr);
        epoch_expect = n;
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        if (n == 0) begin
            assert (epoch_done && !busy) else begin
                errors++;
                $display("epoch with zero samples did not end right after start");
            end
        end
        if (poke) begin
            repeat (10) next_cycle();
            start = 1'b1; // epoch is running, this one is dropped
            next_cycle();
            start = 1'b0;
        end
        while (!epoch_done) begin
            next_cycle();
        end
        next_cycle();
    endtask

    initial begin
        void'($urandom(SEED));
        clk        = 1'b0;
        rst        = 1'b1;
        smp_wr     = 1'b0;
        smp_addr   = '0;
        smp_input  = '0;
        smp_target = '0;
        wt_wr      = 1'b0;
        wt_addr    = '0;
        wt_wdata   = '0;
        cfg_wr     = 1'b0;
        cfg_addr   = CFG_NUM_SAMPLES;
        cfg_wdata  = '0;
        start      = 1'b0;
        epoch_expect = 0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        assert ({busy, sample_done, epoch_done} == 3'b000) else begin
            errors++;
            $display("ERROR busy/sample_done/epoch_done expected 0 got %h",
                     {busy, sample_done, epoch_done});
        end
        check_cfg(CFG_NUM_SAMPLES, 16'h0000);
        check_cfg(CFG_LR_SHIFT, 16'h0000);
        write_cfg(CFG_NUM_SAMPLES, 16'hffe3);
        write_cfg(CFG_LR_SHIFT, 16'h00a7);
        check_cfg(CFG_NUM_SAMPLES, 16'h0003); // 5-bit count
        check_cfg(CFG_LR_SHIFT, 16'h0007);

        load_samples();
        load_weights(192);
        run_epoch(RUN_SAMPLES, 2, 1'b1);
        check_weights();
        run_epoch(RUN_SAMPLES, 5, 1'b0); // starts over at sample 0 with trained weights
        check_weights();

        load_weights(24576); // up to +-96.0, drives both layers into saturation
        run_epoch(RUN_SAMPLES, 3, 1'b0);
        check_weights();
        run_epoch(0, 3, 1'b0);

        repeat (3) next_cycle();
        $display("samples compared %0d, errors %0d", smp_seen, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("samples compared %0d, errors %0d", smp_seen, errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* compile.f */
+incdir+tests
hw/nn_fixed_pkg.sv
hw/nn_ctrl_pkg.sv
hw/sample_mem.sv
hw/train_config.sv
hw/activation_stack.sv
hw/forward_layer.sv
hw/backpropagator.sv
hw/train_controller.sv
hw/nn_trainer.sv
tests/tb_nn_trainer.sv
